/* compile.f */
hdl/hyper_udma_pkg.sv
hdl/l2_scratch_mem.sv
hdl/cfg_regs.sv
hdl/rx_writer.sv
hdl/tx_streamer.sv
hdl/hyper_udma_top.sv
tests/tb_hyper_udma.sv

/* hdl/cfg_regs.sv */
////////////////////////////////////////
// Channel configuration registers
// Four-phase req/ack slave, RX/TX setup and status
////////////////////////////////////////
`default_nettype none

module cfg_regs (
    input  wire                             sys_clk,
    input  wire                             rst_n,
    input  wire hyper_udma_pkg::cfg_req_t   cfg_req_i,
    output hyper_udma_pkg::cfg_rsp_t        cfg_rsp_o,
    output hyper_udma_pkg::chan_setup_t     rx_setup_o,
    output hyper_udma_pkg::chan_setup_t     tx_setup_o,
    input  wire                             rx_busy_i,
    input  wire                             tx_busy_i
);

    logic                                   ack_q;
    logic [31:0]                            rdata_q;
    logic [31:0]                            rd_mux;
    logic                                   access;
    logic                                   wr_access;
    logic [hyper_udma_pkg::L2_AWIDTH-1:0]   rx_saddr_q;
    logic [hyper_udma_pkg::L2_AWIDTH-1:0]   tx_saddr_q;
    logic [hyper_udma_pkg::TRANS_SIZE-1:0]  rx_size_q;
    logic [hyper_udma_pkg::TRANS_SIZE-1:0]  tx_size_q;
    logic [31:0]                            rx_cfg_q;
    logic [31:0]                            tx_cfg_q;
    logic                                   rx_start_q;
    logic                                   tx_start_q;

    // New request seen while ack is still low
    assign access    = cfg_req_i.req & ~ack_q;
    assign wr_access = access & ~cfg_req_i.rwn;

    ////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////
    always_comb begin
        rd_mux = '0;
        case (cfg_req_i.addr)
            hyper_udma_pkg::REG_RX_SADDR: rd_mux[hyper_udma_pkg::L2_AWIDTH-1:0] = rx_saddr_q;
            hyper_udma_pkg::REG_RX_SIZE:  rd_mux[hyper_udma_pkg::TRANS_SIZE-1:0] = rx_size_q;
            hyper_udma_pkg::REG_TX_SADDR: rd_mux[hyper_udma_pkg::L2_AWIDTH-1:0] = tx_saddr_q;
            hyper_udma_pkg::REG_TX_SIZE:  rd_mux[hyper_udma_pkg::TRANS_SIZE-1:0] = tx_size_q;
            hyper_udma_pkg::REG_RX_CFG: begin
                rd_mux                             = rx_cfg_q;
                rd_mux[hyper_udma_pkg::CFG_EN_BIT] = rx_busy_i;   // Enable reads as busy
            end
            hyper_udma_pkg::REG_TX_CFG: begin
                rd_mux                             = tx_cfg_q;
                rd_mux[hyper_udma_pkg::CFG_EN_BIT] = tx_busy_i;
            end
            hyper_udma_pkg::REG_STATUS: begin
                rd_mux[hyper_udma_pkg::STAT_TX_BUSY_BIT] = tx_busy_i;
                rd_mux[hyper_udma_pkg::STAT_RX_BUSY_BIT] = rx_busy_i;
            end
            default: ;                                            // Unmapped reads zero
        endcase
    end

    ////////////////////////////////////////
    // Handshake and register writes
    ////////////////////////////////////////
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q      <= 1'b0;
            rdata_q    <= '0;
            rx_saddr_q <= '0;
            tx_saddr_q <= '0;
            rx_size_q  <= '0;
            tx_size_q  <= '0;
            rx_cfg_q   <= '0;
            tx_cfg_q   <= '0;
            rx_start_q <= 1'b0;
            tx_start_q <= 1'b0;
        end else begin
            rx_start_q <= 1'b0;
            tx_start_q <= 1'b0;
            if (access) begin
                ack_q   <= 1'b1;                                  // Raised one cycle after req
                rdata_q <= cfg_req_i.rwn ? rd_mux : '0;
            end else if (!cfg_req_i.req) begin
                ack_q   <= 1'b0;                                  // Dropped one cycle after req
            end
            if (wr_access) begin
                case (cfg_req_i.addr)
                    hyper_udma_pkg::REG_RX_SADDR:
                        rx_saddr_q <= cfg_req_i.wdata[hyper_udma_pkg::L2_AWIDTH-1:0];
                    hyper_udma_pkg::REG_RX_SIZE:
                        rx_size_q <= cfg_req_i.wdata[hyper_udma_pkg::TRANS_SIZE-1:0];
                    hyper_udma_pkg::REG_TX_SADDR:
                        tx_saddr_q <= cfg_req_i.wdata[hyper_udma_pkg::L2_AWIDTH-1:0];
                    hyper_udma_pkg::REG_TX_SIZE:
                        tx_size_q <= cfg_req_i.wdata[hyper_udma_pkg::TRANS_SIZE-1:0];
                    hyper_udma_pkg::REG_RX_CFG: begin
                        rx_cfg_q   <= cfg_req_i.wdata;
                        rx_start_q <= cfg_req_i.wdata[hyper_udma_pkg::CFG_EN_BIT];
                    end
                    hyper_udma_pkg::REG_TX_CFG: begin
                        tx_cfg_q   <= cfg_req_i.wdata;
                        tx_start_q <= cfg_req_i.wdata[hyper_udma_pkg::CFG_EN_BIT];
                    end
                    default: ;
                endcase
            end
        end
    end

    assign cfg_rsp_o.ack   = ack_q;
    assign cfg_rsp_o.rdata = rdata_q;

    assign rx_setup_o.start_addr = rx_saddr_q;
    assign rx_setup_o.size       = rx_size_q;
    assign rx_setup_o.start      = rx_start_q;
    assign tx_setup_o.start_addr = tx_saddr_q;
    assign tx_setup_o.size       = tx_size_q;
    assign tx_setup_o.start      = tx_start_q;

    // Slave must never acknowledge a request the master did not make
    ack_needs_req: assert property (@(posedge sys_clk) disable iff (!rst_n)
        $rose(ack_q) |-> $past(cfg_req_i.req));

endmodule

`default_nettype wire

/* hdl/hyper_udma_pkg.sv */
////////////////////////////////////////
// HyperBus UDMA channel front end
// Register map, widths and shared structs
////////////////////////////////////////
`default_nettype none

package hyper_udma_pkg;

    // Widths and sizes
    localparam int L2_AWIDTH  = 12;           // L2 byte address
    localparam int TRANS_SIZE = 16;           // Transfer byte count
    localparam int MEM_DEPTH  = 4096;         // Bytes in L2 scratch
    localparam int WORD_BYTES = 4;            // Bytes per stream word
    localparam int MEM_WORDS  = MEM_DEPTH / WORD_BYTES;

    // Per-word increments in the width they are added to
    localparam logic [L2_AWIDTH-1:0]  ADDR_STEP = L2_AWIDTH'(WORD_BYTES);
    localparam logic [TRANS_SIZE-1:0] SIZE_STEP = TRANS_SIZE'(WORD_BYTES);

    ////////////////////////////////////////
    // Register map, reference numbering
    ////////////////////////////////////////
    localparam logic [4:0] REG_RX_SADDR = 5'd0;
    localparam logic [4:0] REG_RX_SIZE  = 5'd1;
    localparam logic [4:0] REG_RX_CFG   = 5'd2;
    localparam logic [4:0] REG_TX_SADDR = 5'd3;
    localparam logic [4:0] REG_TX_SIZE  = 5'd4;
    localparam logic [4:0] REG_TX_CFG   = 5'd5;
    localparam logic [4:0] REG_STATUS   = 5'd9;  // 6 to 8 not implemented

    localparam int CFG_EN_BIT       = 4;      // Channel enable
    localparam int STAT_TX_BUSY_BIT = 0;
    localparam int STAT_RX_BUSY_BIT = 1;

    ////////////////////////////////////////
    // Shared structs
    ////////////////////////////////////////
    typedef struct packed {
        logic        req;
        logic [4:0]  addr;
        logic        rwn;                     // 1 is read
        logic [31:0] wdata;
    } cfg_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] rdata;
    } cfg_rsp_t;

    typedef struct packed {
        logic [L2_AWIDTH-1:0]  start_addr;
        logic [TRANS_SIZE-1:0] size;
        logic                  start;         // One-cycle kick
    } chan_setup_t;

    // Memory write; addr is a byte address with the low bits clear
    typedef struct packed {
        logic                 we;
        logic [3:0]           be;
        logic [L2_AWIDTH-1:0] addr;
        logic [31:0]          data;
    } mem_wr_t;

endpackage

`default_nettype wire

/* hdl/hyper_udma_top.sv */
////////////////////////////////////////
// HyperBus UDMA channel front end, top
// Register block, RX and TX engines, L2 scratch
////////////////////////////////////////
`default_nettype none

module hyper_udma_top (
    input  wire                            sys_clk,
    input  wire                            rst_n,
    input  wire hyper_udma_pkg::cfg_req_t  cfg_req_i,
    output hyper_udma_pkg::cfg_rsp_t       cfg_rsp_o,
    input  wire  [31:0]                    rx_data_i,
    input  wire                            rx_valid_i,
    output logic                           rx_ready_o,
    output logic [31:0]                    tx_data_o,
    output logic                           tx_valid_o,
    input  wire                            tx_ready_i,
    output logic                           rx_eot_o,
    output logic                           tx_eot_o
);

    hyper_udma_pkg::chan_setup_t           rx_setup;
    hyper_udma_pkg::chan_setup_t           tx_setup;
    hyper_udma_pkg::mem_wr_t               mem_wr;
    logic                                  rx_busy;
    logic                                  tx_busy;
    logic                                  rd_en;
    logic [hyper_udma_pkg::L2_AWIDTH-1:0]  rd_addr;
    logic [31:0]                           rd_data;

    cfg_regs cfg_regs_inst (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .cfg_req_i  (cfg_req_i),
        .cfg_rsp_o  (cfg_rsp_o),
        .rx_setup_o (rx_setup),
        .tx_setup_o (tx_setup),
        .rx_busy_i  (rx_busy),
        .tx_busy_i  (tx_busy)
    );

    rx_writer rx_writer_inst (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .setup_i    (rx_setup),
        .rx_data_i  (rx_data_i),
        .rx_valid_i (rx_valid_i),
        .rx_ready_o (rx_ready_o),
        .mem_wr_o   (mem_wr),
        .busy_o     (rx_busy),
        .eot_o      (rx_eot_o)
    );

    tx_streamer tx_streamer_inst (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .setup_i    (tx_setup),
        .rd_en_o    (rd_en),
        .rd_addr_o  (rd_addr),
        .rd_data_i  (rd_data),
        .tx_data_o  (tx_data_o),
        .tx_valid_o (tx_valid_o),
        .tx_ready_i (tx_ready_i),
        .busy_o     (tx_busy),
        .eot_o      (tx_eot_o)
    );

    l2_scratch_mem l2_scratch_mem_inst (
        .sys_clk    (sys_clk),
        .rd_en_i    (rd_en),
        .rd_addr_i  (rd_addr),
        .rd_data_o  (rd_data),
        .wr_i       (mem_wr)
    );

endmodule

`default_nettype wire

/* hdl/l2_scratch_mem.sv */
////////////////////////////////////////
// L2 scratch memory, 4 KB in four byte lanes
////////////////////////////////////////
`default_nettype none

module l2_scratch_mem (
    input  wire                                  sys_clk,
    input  wire                                  rd_en_i,
    input  wire  [hyper_udma_pkg::L2_AWIDTH-1:0] rd_addr_i,
    output logic [31:0]                          rd_data_o,
    input  wire hyper_udma_pkg::mem_wr_t         wr_i
);

    // Lane 0 holds the lowest byte address
    logic [hyper_udma_pkg::WORD_BYTES-1:0][7:0] mem_q [hyper_udma_pkg::MEM_WORDS];

    always_ff @(posedge sys_clk) begin
        for (int lane = 0; lane < hyper_udma_pkg::WORD_BYTES; lane++) begin
            if (wr_i.we && wr_i.be[lane]) begin
                mem_q[wr_i.addr[hyper_udma_pkg::L2_AWIDTH-1:2]][lane] <= wr_i.data[8*lane +: 8];
            end
        end
        if (rd_en_i) begin
            rd_data_o <= mem_q[rd_addr_i[hyper_udma_pkg::L2_AWIDTH-1:2]];   // One cycle latency
        end
    end

endmodule

`default_nettype wire

/* hdl/rx_writer.sv */
////////////////////////////////////////
// RX engine
// Writes inbound stream words into L2 with byte enables
////////////////////////////////////////
`default_nettype none

module rx_writer (
    input  wire                              sys_clk,
    input  wire                              rst_n,
    input  wire hyper_udma_pkg::chan_setup_t setup_i,
    input  wire  [31:0]                      rx_data_i,
    input  wire                              rx_valid_i,
    output logic                             rx_ready_o,
    output hyper_udma_pkg::mem_wr_t          mem_wr_o,
    output logic                             busy_o,
    output logic                             eot_o
);

    logic                                   busy_q;
    logic [hyper_udma_pkg::L2_AWIDTH-1:0]   waddr_q;
    logic [hyper_udma_pkg::TRANS_SIZE-1:0]  bytes_left_q;
    logic                                   start_ok;
    logic                                   handshake;
    logic                                   last_word;
    logic [3:0]                             last_be;

    assign start_ok  = setup_i.start & ~busy_q & (setup_i.size != '0);
    assign handshake = rx_valid_i & busy_q;
    assign last_word = bytes_left_q <= hyper_udma_pkg::SIZE_STEP;

    // Low lanes of a short final word
    always_comb begin
        case (bytes_left_q[1:0])
            2'd1:    last_be = 4'b0001;
            2'd2:    last_be = 4'b0011;
            2'd3:    last_be = 4'b0111;
            default: last_be = 4'b1111;
        endcase
    end

    assign rx_ready_o    = busy_q;
    assign busy_o        = busy_q;
    assign eot_o         = handshake & last_word;
    assign mem_wr_o.we   = handshake;
    assign mem_wr_o.be   = last_word ? last_be : 4'b1111;
    assign mem_wr_o.addr = waddr_q;
    assign mem_wr_o.data = rx_data_i;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q       <= 1'b0;
            waddr_q      <= '0;
            bytes_left_q <= '0;
        end else if (start_ok) begin
            busy_q       <= 1'b1;
            waddr_q      <= {setup_i.start_addr[hyper_udma_pkg::L2_AWIDTH-1:2], 2'b00};
            bytes_left_q <= setup_i.size;
        end else if (handshake) begin
            waddr_q      <= waddr_q + hyper_udma_pkg::ADDR_STEP;
            bytes_left_q <= last_word ? '0 : bytes_left_q - hyper_udma_pkg::SIZE_STEP;
            if (last_word) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Busy and the byte count must fall together
    rx_no_spare_write: assert property (@(posedge sys_clk) disable iff (!rst_n)
        mem_wr_o.we |-> (bytes_left_q != '0));

endmodule

`default_nettype wire

/* hdl/tx_streamer.sv */
////////////////////////////////////////
// TX engine
// Reads L2 words and offers them on a valid/ready stream
////////////////////////////////////////
`default_nettype none

module tx_streamer (
    input  wire                                  sys_clk,
    input  wire                                  rst_n,
    input  wire hyper_udma_pkg::chan_setup_t     setup_i,
    output logic                                 rd_en_o,
    output logic [hyper_udma_pkg::L2_AWIDTH-1:0] rd_addr_o,
    input  wire  [31:0]                          rd_data_i,
    output logic [31:0]                          tx_data_o,
    output logic                                 tx_valid_o,
    input  wire                                  tx_ready_i,
    output logic                                 busy_o,
    output logic                                 eot_o
);

    logic                                   busy_q;
    logic                                   valid_q;
    logic [hyper_udma_pkg::L2_AWIDTH-1:0]   rd_addr_q;
    logic [hyper_udma_pkg::TRANS_SIZE-1:0]  rd_bytes_q;   // Bytes not yet read
    logic [hyper_udma_pkg::TRANS_SIZE-1:0]  tx_bytes_q;   // Bytes not yet sent
    logic                                   start_ok;
    logic                                   handshake;
    logic                                   last_word;

    assign start_ok  = setup_i.start & ~busy_q & (setup_i.size != '0);
    assign handshake = valid_q & tx_ready_i;
    assign last_word = tx_bytes_q <= hyper_udma_pkg::SIZE_STEP;

    // Read when the port is empty or is being emptied this cycle
    assign rd_en_o   = busy_q & (rd_bytes_q != '0) & (~valid_q | tx_ready_i);
    assign rd_addr_o = rd_addr_q;

    // Memory output register holds the port word
    assign tx_data_o  = rd_data_i;
    assign tx_valid_o = valid_q;
    assign busy_o     = busy_q;
    assign eot_o      = handshake & last_word;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q     <= 1'b0;
            valid_q    <= 1'b0;
            rd_addr_q  <= '0;
            rd_bytes_q <= '0;
            tx_bytes_q <= '0;
        end else if (start_ok) begin
            busy_q     <= 1'b1;
            valid_q    <= 1'b0;
            rd_addr_q  <= setup_i.start_addr;
            rd_bytes_q <= setup_i.size;
            tx_bytes_q <= setup_i.size;
        end else begin
            if (rd_en_o) begin
                rd_addr_q  <= rd_addr_q + hyper_udma_pkg::ADDR_STEP;
                rd_bytes_q <= (rd_bytes_q <= hyper_udma_pkg::SIZE_STEP) ? '0 :
                              rd_bytes_q - hyper_udma_pkg::SIZE_STEP;
                valid_q    <= 1'b1;                   // Data lands next cycle
            end else if (handshake) begin
                valid_q    <= 1'b0;
            end
            if (handshake) begin
                tx_bytes_q <= last_word ? '0 : tx_bytes_q - hyper_udma_pkg::SIZE_STEP;
                if (last_word) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // Stalled word must hold, which relies on the memory only updating on rd_en
    tx_hold_stable: assert property (@(posedge sys_clk) disable iff (!rst_n)
        (tx_valid_o && !tx_ready_i) |=> (tx_valid_o && $stable(tx_data_o)));

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the HyperBus UDMA testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module tb_hyper_udma \
    -Mdir obj_dir -f compile.f

output=$(./obj_dir/Vtb_hyper_udma 2>&1) || true
echo "$output"

if echo "$output" | grep -q "^TEST RESULT: PASS$"; then
    exit 0
fi
exit 1

/* tests/tb_hyper_udma.sv */
////////////////////////////////////////
// Testbench for the HyperBus UDMA front end
// Directed register, RX fill and TX stream tests
////////////////////////////////////////
`default_nettype none

module tb_hyper_udma;

    timeunit 1ns;
    timeprecision 1ps;

    // Longest test is well under 1000 cycles even with back-pressure
    localparam int          MAX_CYCLES = 4000;
    localparam logic [31:0] EN_WORD    = 32'h1 << hyper_udma_pkg::CFG_EN_BIT;
    localparam logic [31:0] RX_BUSY    = 32'h1 << hyper_udma_pkg::STAT_RX_BUSY_BIT;

    logic                     sys_clk;
    logic                     rst_n;
    hyper_udma_pkg::cfg_req_t cfg_req;
    hyper_udma_pkg::cfg_rsp_t cfg_rsp;
    logic [31:0]              rx_data;
    logic                     rx_valid;
    logic                     rx_ready;
    logic [31:0]              tx_data;
    logic                     tx_valid;
    logic                     tx_ready;
    logic                     rx_eot;
    logic                     tx_eot;

    integer      seed           = 32'h2c14;
    int          errors         = 0;
    int          checks         = 0;
    int          cycles         = 0;
    int          rx_eot_count   = 0;
    int          tx_eot_count   = 0;
    logic        watch_idle     = 1'b0;
    logic        stray_activity = 1'b0;
    logic [31:0] send_buf [8];
    logic [31:0] got_buf [8];
    logic [31:0] mem_exp [8];                 // Expected L2 words from 0x100 up

    hyper_udma_top hyper_udma_top_inst (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .cfg_req_i  (cfg_req),
        .cfg_rsp_o  (cfg_rsp),
        .rx_data_i  (rx_data),
        .rx_valid_i (rx_valid),
        .rx_ready_o (rx_ready),
        .tx_data_o  (tx_data),
        .tx_valid_o (tx_valid),
        .tx_ready_i (tx_ready),
        .rx_eot_o   (rx_eot),
        .tx_eot_o   (tx_eot)
    );

    always #5 sys_clk = ~sys_clk;

    always @(posedge sys_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: no result after %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Outputs are settled at the falling edge
    always @(negedge sys_clk) begin
        if (rx_eot) begin
            rx_eot_count++;
        end
        if (tx_eot) begin
            tx_eot_count++;
        end
        if (watch_idle && (tx_valid || rx_ready)) begin
            stray_activity = 1'b1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp)
        else begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    ////////////////////////////////////////
    // Bus and stream drivers
    ////////////////////////////////////////
    task automatic cfg_access(input logic [4:0] addr, input logic rwn,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge sys_clk);
        #1;
        cfg_req.req   = 1'b1;
        cfg_req.addr  = addr;
        cfg_req.rwn   = rwn;
        cfg_req.wdata = wdata;
        do begin
            @(posedge sys_clk);
            #1;
        end while (!cfg_rsp.ack);
        rdata       = cfg_rsp.rdata;              // Valid while ack is high
        cfg_req.req = 1'b0;
        do begin
            @(posedge sys_clk);
            #1;
        end while (cfg_rsp.ack);
    endtask

    task automatic cfg_write(input logic [4:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        cfg_access(addr, 1'b0, data, unused);
    endtask

    task automatic cfg_read(input logic [4:0] addr, output logic [31:0] data);
        cfg_access(addr, 1'b1, 32'd0, data);
    endtask

    task automatic rx_send(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge sys_clk);
            #1;
            rx_valid = 1'b1;
            rx_data  = send_buf[i];
            @(negedge sys_clk);
            while (!rx_ready) begin
                @(negedge sys_clk);
            end
        end
        @(posedge sys_clk);                       // Last word taken here
        #1;
        rx_valid = 1'b0;
    endtask

    task automatic tx_collect(input int n);
        int got;
        got = 0;
        while (got < n) begin
            @(posedge sys_clk);
            #1;
            tx_ready = ($random(seed) & 3) != 0;  // Stall about one cycle in four
            @(negedge sys_clk);
            if (tx_valid && tx_ready) begin
                got_buf[got] = tx_data;
                check_value("tx_collect eot", 32'(got == n - 1), 32'(tx_eot));
                got++;
            end
        end
        @(posedge sys_clk);
        #1;
        tx_ready = 1'b0;
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////
    task automatic reg_defaults_and_readback();
        logic [4:0]  addrs [7];
        logic [31:0] rd;
        addrs = '{hyper_udma_pkg::REG_RX_SADDR, hyper_udma_pkg::REG_RX_SIZE,
                  hyper_udma_pkg::REG_RX_CFG, hyper_udma_pkg::REG_TX_SADDR,
                  hyper_udma_pkg::REG_TX_SIZE, hyper_udma_pkg::REG_TX_CFG,
                  hyper_udma_pkg::REG_STATUS};
        for (int i = 0; i < 7; i++) begin
            cfg_read(addrs[i], rd);
            check_value("reg_defaults", 32'd0, rd);
        end
        cfg_write(hyper_udma_pkg::REG_RX_SADDR, 32'h0000_0a5c);
        cfg_write(hyper_udma_pkg::REG_RX_SIZE, 32'h0000_1234);
        cfg_write(hyper_udma_pkg::REG_TX_SADDR, 32'h0000_03f0);
        cfg_write(hyper_udma_pkg::REG_TX_SIZE, 32'h0000_beef);
        cfg_read(hyper_udma_pkg::REG_RX_SADDR, rd);
        check_value("reg_readback", 32'h0000_0a5c, rd);
        cfg_read(hyper_udma_pkg::REG_RX_SIZE, rd);
        check_value("reg_readback", 32'h0000_1234, rd);
        cfg_read(hyper_udma_pkg::REG_TX_SADDR, rd);
        check_value("reg_readback", 32'h0000_03f0, rd);
        cfg_read(hyper_udma_pkg::REG_TX_SIZE, rd);
        check_value("reg_readback", 32'h0000_beef, rd);
    endtask

    task automatic rx_fill();
        logic [31:0] rd;
        int          eot_before;
        cfg_write(hyper_udma_pkg::REG_RX_SADDR, 32'h100);
        cfg_write(hyper_udma_pkg::REG_RX_SIZE, 32'd32);
        cfg_write(hyper_udma_pkg::REG_RX_CFG, EN_WORD);
        cfg_read(hyper_udma_pkg::REG_STATUS, rd);
        check_value("rx_fill busy", RX_BUSY, rd);
        for (int i = 0; i < 8; i++) begin
            send_buf[i] = $random(seed);
            mem_exp[i]  = send_buf[i];
        end
        eot_before = rx_eot_count;
        rx_send(8);
        cfg_read(hyper_udma_pkg::REG_STATUS, rd);
        check_value("rx_fill idle", 32'd0, rd);
        check_value("rx_fill eot count", 32'd1, rx_eot_count - eot_before);
        check_value("rx_fill ready", 32'd0, 32'(rx_ready));
    endtask

    task automatic tx_readback();
        int eot_before;
        eot_before = tx_eot_count;
        cfg_write(hyper_udma_pkg::REG_TX_SADDR, 32'h100);
        cfg_write(hyper_udma_pkg::REG_TX_SIZE, 32'd32);
        cfg_write(hyper_udma_pkg::REG_TX_CFG, EN_WORD);
        tx_collect(8);
        for (int i = 0; i < 8; i++) begin
            check_value("tx_readback", mem_exp[i], got_buf[i]);
        end
        check_value("tx_readback eot count", 32'd1, tx_eot_count - eot_before);
    endtask

    task automatic partial_last_word();
        cfg_write(hyper_udma_pkg::REG_RX_SADDR, 32'h100);
        cfg_write(hyper_udma_pkg::REG_RX_SIZE, 32'd6);
        cfg_write(hyper_udma_pkg::REG_RX_CFG, EN_WORD);
        send_buf[0] = $random(seed);
        send_buf[1] = $random(seed);
        rx_send(2);
        mem_exp[0] = send_buf[0];
        mem_exp[1] = {mem_exp[1][31:16], send_buf[1][15:0]};  // 6 mod 4 leaves two lanes
        cfg_write(hyper_udma_pkg::REG_TX_SIZE, 32'd8);
        cfg_write(hyper_udma_pkg::REG_TX_CFG, EN_WORD);
        tx_collect(2);
        check_value("partial_last_word", mem_exp[0], got_buf[0]);
        check_value("partial_last_word", mem_exp[1], got_buf[1]);
    endtask

    task automatic ignored_starts();
        logic [31:0] rd;
        stray_activity = 1'b0;
        watch_idle     = 1'b1;
        cfg_write(hyper_udma_pkg::REG_RX_SIZE, 32'd0);
        cfg_write(hyper_udma_pkg::REG_RX_CFG, EN_WORD);
        cfg_write(hyper_udma_pkg::REG_TX_SIZE, 32'd0);
        cfg_write(hyper_udma_pkg::REG_TX_CFG, EN_WORD);
        cfg_read(hyper_udma_pkg::REG_STATUS, rd);
        check_value("ignored_starts status", 32'd0, rd);
        repeat (8) @(posedge sys_clk);
        watch_idle = 1'b0;
        checks++;
        assert (!stray_activity)
        else begin
            errors++;
            $display("ignored_starts: a stream became active after an enable with size zero");
        end
        // Second enable lands while the first transfer is stalled
        cfg_write(hyper_udma_pkg::REG_TX_SADDR, 32'h100);
        cfg_write(hyper_udma_pkg::REG_TX_SIZE, 32'd32);
        cfg_write(hyper_udma_pkg::REG_TX_CFG, EN_WORD);
        cfg_write(hyper_udma_pkg::REG_TX_SADDR, 32'h180);
        cfg_write(hyper_udma_pkg::REG_TX_SIZE, 32'd8);
        cfg_write(hyper_udma_pkg::REG_TX_CFG, EN_WORD);
        tx_collect(8);
        for (int i = 0; i < 8; i++) begin
            check_value("ignored_starts busy enable", mem_exp[i], got_buf[i]);
        end
        cfg_read(hyper_udma_pkg::REG_STATUS, rd);
        check_value("ignored_starts idle", 32'd0, rd);
    endtask

    initial begin
        sys_clk  = 1'b0;
        rst_n    = 1'b0;
        cfg_req  = '0;
        rx_data  = '0;
        rx_valid = 1'b0;
        tx_ready = 1'b0;
        repeat (2) @(posedge sys_clk);
        #1;
        rst_n = 1'b1;
        reg_defaults_and_readback();
        rx_fill();
        tx_readback();
        partial_last_word();
        ignored_starts();
        repeat (2) @(posedge sys_clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
